//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Signed immediate offset on the request
    localparam int OFFSET_WIDTH = 12;

    // Scratch region is 4 KiB at the bottom of the address map
    localparam logic [XLEN-1:0] SCRATCH_BASE = 32'h0000_0000;
    localparam int SCRATCH_ADDR_BITS = 12;
    localparam int SCRATCH_WORDS = 1024;

    // Buffering
    localparam int INPUT_DEPTH = 4;
    localparam int MAX_INFLIGHT = 2;
    localparam int WB_CREDITS = 2;

    // Access width, fn3 encoding
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } ls_width_e;

    // Target sub-unit
    typedef enum logic {
        UNIT_SCRATCH = 1'b0,
        UNIT_BUS     = 1'b1
    } ls_unit_e;

endpackage

`default_nettype wire

//--- src/lsu_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid,
    output logic                  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic wr_en;
    logic rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= data_in;
    end

    // Head entry is visible as soon as it is written
    assign data_out = mem[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- src/ls_request_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ls_request_decode (
    input  logic [lsu_pkg::XLEN-1:0]         base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0] offset,
    input  lsu_pkg::ls_width_e               width,
    input  logic                             store,
    input  logic [lsu_pkg::XLEN-1:0]         store_data,
    output logic [lsu_pkg::XLEN-1:0]         addr,
    output logic [lsu_pkg::XLEN/8-1:0]       be,
    output logic [lsu_pkg::XLEN-1:0]         wdata,
    output logic                             misaligned,
    output lsu_pkg::ls_unit_e                unit
);

    import lsu_pkg::*;

    // Base plus sign-extended immediate
    assign addr = base + {{(XLEN-OFFSET_WIDTH){offset[OFFSET_WIDTH-1]}}, offset};

    always_comb begin
        case (width)
            HALF, HALF_U: misaligned = addr[0];
            WORD:         misaligned = |addr[1:0];
            default:      misaligned = 1'b0;
        endcase
    end

    // Byte enables are only raised for stores
    always_comb begin
        be = '0;
        if (store) begin
            case (width)
                BYTE, BYTE_U: be[addr[1:0]] = 1'b1;
                HALF, HALF_U: be = addr[1] ? 4'b1100 : 4'b0011;
                default:      be = 4'b1111;
            endcase
        end
    end

    // Replicate narrow store data across all byte lanes
    always_comb begin
        case (width)
            BYTE, BYTE_U: wdata = {4{store_data[7:0]}};
            HALF, HALF_U: wdata = {2{store_data[15:0]}};
            default:      wdata = store_data;
        endcase
    end

    assign unit = (addr[XLEN-1:SCRATCH_ADDR_BITS] == SCRATCH_BASE[XLEN-1:SCRATCH_ADDR_BITS])
                ? UNIT_SCRATCH : UNIT_BUS;

endmodule

`default_nettype wire

//--- src/scratch_ram.sv
`timescale 1ns/10ps
`default_nettype none

module scratch_ram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_request,
    input  logic                       load,
    input  logic [lsu_pkg::XLEN/8-1:0] be,
    input  logic [lsu_pkg::XLEN-1:0]   addr,
    input  logic [lsu_pkg::XLEN-1:0]   wdata,
    output logic                       unit_ready,
    output logic                       data_valid,
    output logic [lsu_pkg::XLEN-1:0]   data
);

    import lsu_pkg::*;

    logic [XLEN-1:0] mem [SCRATCH_WORDS];
    logic [XLEN-1:0] rdata;
    logic [SCRATCH_ADDR_BITS-3:0] word_idx;

    assign word_idx = addr[SCRATCH_ADDR_BITS-1:2];

    // Per-byte write, read word registered for one-cycle latency
    always_ff @(posedge clk) begin
        if (new_request && !load) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be[i])
                    mem[word_idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
        if (new_request && load)
            rdata <= mem[word_idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else
            data_valid <= new_request && load;
    end

    assign data = data_valid ? rdata : '0;
    assign unit_ready = 1'b1;

endmodule

`default_nettype wire

//--- src/mem_bus_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_bus_port (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_request,
    input  logic                       load,
    input  logic [lsu_pkg::XLEN/8-1:0] be,
    input  logic [lsu_pkg::XLEN-1:0]   addr,
    input  logic [lsu_pkg::XLEN-1:0]   wdata,
    input  logic                       bus_gnt,
    input  logic                       bus_rvalid,
    input  logic [lsu_pkg::XLEN-1:0]   bus_rdata,
    output logic                       unit_ready,
    output logic                       data_valid,
    output logic [lsu_pkg::XLEN-1:0]   data,
    output logic                       bus_req,
    output logic                       bus_we,
    output logic [lsu_pkg::XLEN-1:0]   bus_addr,
    output logic [lsu_pkg::XLEN/8-1:0] bus_be,
    output logic [lsu_pkg::XLEN-1:0]   bus_wdata
);

    typedef enum logic {
        IDLE,
        REQ
    } bus_state_e;

    bus_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (new_request) state <= REQ;
                REQ:  if (bus_gnt) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Payload captured once and held until grant
    always_ff @(posedge clk) begin
        if (new_request && state == IDLE) begin
            bus_we <= ~load;
            bus_addr <= addr;
            bus_be <= be;
            bus_wdata <= wdata;
        end
    end

    assign bus_req = (state == REQ);
    assign unit_ready = (state == IDLE);

    // Read responses come back in order
    assign data_valid = bus_rvalid;
    assign data = bus_rvalid ? bus_rdata : '0;

endmodule

`default_nettype wire

//--- src/load_align.sv
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input  logic [lsu_pkg::XLEN-1:0] raw_data,
    input  logic [1:0]               byte_offset,
    input  lsu_pkg::ls_width_e       width,
    output logic [lsu_pkg::XLEN-1:0] load_data
);

    import lsu_pkg::*;

    logic [XLEN-1:0] shifted;

    // Bring the addressed lane down to bit 0
    assign shifted = raw_data >> {byte_offset, 3'b000};

    always_comb begin
        case (width)
            BYTE:    load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            HALF:    load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            BYTE_U:  load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
            HALF_U:  load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic                             req_load,
    input  logic                             req_store,
    input  lsu_pkg::ls_width_e               req_width,
    input  logic [lsu_pkg::XLEN-1:0]         req_base,
    input  logic [lsu_pkg::OFFSET_WIDTH-1:0] req_offset,
    input  logic [lsu_pkg::XLEN-1:0]         req_store_data,

    output logic                             wb_valid,
    output logic [lsu_pkg::XLEN-1:0]         wb_data,
    input  logic                             wb_credit_return,

    output logic                             misaligned,

    output logic                             bus_req,
    output logic                             bus_we,
    output logic [lsu_pkg::XLEN-1:0]         bus_addr,
    output logic [lsu_pkg::XLEN/8-1:0]       bus_be,
    output logic [lsu_pkg::XLEN-1:0]         bus_wdata,
    input  logic                             bus_gnt,
    input  logic                             bus_rvalid,
    input  logic [lsu_pkg::XLEN-1:0]         bus_rdata
);

    import lsu_pkg::*;

    localparam int INFLIGHT_W = $clog2(MAX_INFLIGHT + 1);
    localparam int CREDIT_W = $clog2(WB_CREDITS + 1);

    logic [2*XLEN+OFFSET_WIDTH+4:0] req_packed;
    logic [2*XLEN+OFFSET_WIDTH+4:0] rq_packed;
    logic rq_valid;
    logic rq_full;
    logic rq_pop;
    logic rq_load;
    logic rq_store;
    logic [2:0] rq_width_bits;
    ls_width_e rq_width;
    logic [XLEN-1:0] rq_base;
    logic [OFFSET_WIDTH-1:0] rq_offset;
    logic [XLEN-1:0] rq_store_data;

    logic [XLEN-1:0] addr;
    logic [XLEN/8-1:0] be;
    logic [XLEN-1:0] wdata;
    logic addr_misaligned;
    ls_unit_e unit;

    logic issue_request;
    logic units_ready;
    logic load_ok;
    logic unit_stall;
    ls_unit_e last_unit;
    logic [INFLIGHT_W-1:0] inflight;

    logic scratch_ready;
    logic scratch_valid;
    logic [XLEN-1:0] scratch_data;
    logic bus_ready;
    logic bus_valid;
    logic [XLEN-1:0] bus_data;
    logic data_valid;
    logic [XLEN-1:0] raw_data;

    logic attr_push;
    logic attr_valid;
    logic attr_full;
    logic [4:0] attr_out;
    logic [XLEN-1:0] final_data;

    logic [XLEN-1:0] wb_entry0;
    logic [XLEN-1:0] wb_entry1;
    logic [1:0] wb_count;
    logic [CREDIT_W-1:0] credits;

    // Request buffer
    assign req_packed = {req_load, req_store, req_width, req_base, req_offset, req_store_data};
    assign req_ready = ~rq_full;

    lsu_fifo #(
        .DATA_WIDTH($bits(req_packed)),
        .DEPTH(INPUT_DEPTH)
    ) i_request_fifo (
        .clk(clk),
        .rst(rst),
        .push(req_valid && req_ready),
        .pop(rq_pop),
        .data_in(req_packed),
        .data_out(rq_packed),
        .valid(rq_valid),
        .full(rq_full)
    );

    assign {rq_load, rq_store, rq_width_bits, rq_base, rq_offset, rq_store_data} = rq_packed;
    assign rq_width = ls_width_e'(rq_width_bits);

    ls_request_decode i_ls_request_decode (
        .base(rq_base),
        .offset(rq_offset),
        .width(rq_width),
        .store(rq_store),
        .store_data(rq_store_data),
        .addr(addr),
        .be(be),
        .wdata(wdata),
        .misaligned(addr_misaligned),
        .unit(unit)
    );

    // Issue control
    assign units_ready = scratch_ready && bus_ready;
    assign load_ok = !rq_load || (inflight < INFLIGHT_W'(MAX_INFLIGHT) && !attr_full);
    // No switching units while loads are outstanding, so results cannot collide
    assign unit_stall = (unit != last_unit) && attr_valid;
    assign issue_request = rq_valid && !addr_misaligned && units_ready && load_ok && !unit_stall;

    // Misaligned requests are dropped at the head
    assign misaligned = rq_valid && addr_misaligned;
    assign rq_pop = issue_request || misaligned;

    assign attr_push = issue_request && rq_load;

    always_ff @(posedge clk) begin
        if (rst)
            last_unit <= UNIT_SCRATCH;
        else if (attr_push)
            last_unit <= unit;
    end

    // Loads count until their result leaves the writeback buffer
    always_ff @(posedge clk) begin
        if (rst)
            inflight <= '0;
        else if (attr_push && !wb_valid)
            inflight <= inflight + 1'b1;
        else if (!attr_push && wb_valid)
            inflight <= inflight - 1'b1;
    end

    scratch_ram i_scratch_ram (
        .clk(clk),
        .rst(rst),
        .new_request(issue_request && unit == UNIT_SCRATCH),
        .load(rq_load),
        .be(be),
        .addr(addr),
        .wdata(wdata),
        .unit_ready(scratch_ready),
        .data_valid(scratch_valid),
        .data(scratch_data)
    );

    mem_bus_port i_mem_bus_port (
        .clk(clk),
        .rst(rst),
        .new_request(issue_request && unit == UNIT_BUS),
        .load(rq_load),
        .be(be),
        .addr(addr),
        .wdata(wdata),
        .bus_gnt(bus_gnt),
        .bus_rvalid(bus_rvalid),
        .bus_rdata(bus_rdata),
        .unit_ready(bus_ready),
        .data_valid(bus_valid),
        .data(bus_data),
        .bus_req(bus_req),
        .bus_we(bus_we),
        .bus_addr(bus_addr),
        .bus_be(bus_be),
        .bus_wdata(bus_wdata)
    );

    // Unit outputs are zero when idle
    assign data_valid = scratch_valid || bus_valid;
    assign raw_data = scratch_data | bus_data;

    // Width and byte offset of each outstanding load
    lsu_fifo #(
        .DATA_WIDTH(5),
        .DEPTH(MAX_INFLIGHT)
    ) i_attr_fifo (
        .clk(clk),
        .rst(rst),
        .push(attr_push),
        .pop(data_valid),
        .data_in({rq_width, addr[1:0]}),
        .data_out(attr_out),
        .valid(attr_valid),
        .full(attr_full)
    );

    load_align i_load_align (
        .raw_data(raw_data),
        .byte_offset(attr_out[1:0]),
        .width(ls_width_e'(attr_out[4:2])),
        .load_data(final_data)
    );

    // Two-entry writeback buffer, newest result in entry0
    always_ff @(posedge clk) begin
        if (data_valid) begin
            wb_entry0 <= final_data;
            wb_entry1 <= wb_entry0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            wb_count <= '0;
        else if (data_valid && !wb_valid)
            wb_count <= wb_count + 1'b1;
        else if (!data_valid && wb_valid)
            wb_count <= wb_count - 1'b1;
    end

    // One credit spent per result, one restored per return pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(WB_CREDITS);
        end else begin
            case ({wb_valid, wb_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign wb_valid = (wb_count != '0) && (credits != '0);
    assign wb_data = (wb_count == 2'd2) ? wb_entry1 : wb_entry0;

endmodule

`default_nettype wire

//--- verification/lsu_props.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_props (
    input wire logic                                            clk,
    input wire logic                                            rst,
    input wire logic                                            wb_valid,
    input wire logic                                            wb_credit_return,
    input wire logic                                            bus_req,
    input wire logic                                            bus_gnt,
    input wire logic                                            bus_we,
    input wire logic [lsu_pkg::XLEN-1:0]                        bus_addr,
    input wire logic [lsu_pkg::XLEN/8-1:0]                      bus_be,
    input wire logic [lsu_pkg::XLEN-1:0]                        bus_wdata,
    input wire logic                                            misaligned,
    input wire logic                                            issue_request,
    input wire logic [lsu_pkg::XLEN-1:0]                        addr,
    input wire logic [2:0]                                      width
);

    import lsu_pkg::*;

    int avail;
    logic unaligned;

    // Credits as seen from the writeback ports alone
    always_ff @(posedge clk) begin
        if (rst)
            avail <= WB_CREDITS;
        else
            avail <= avail + int'(wb_credit_return) - int'(wb_valid);
    end

    // Alignment rule on the decoded address
    assign unaligned = ((width == HALF || width == HALF_U) && addr[0])
                    || (width == WORD && addr[1:0] != 2'b00);

    // Writeback only with a credit in hand
    assert property (@(posedge clk) disable iff (rst) wb_valid |-> avail > 0)
        else $error("wb_valid raised with no credits");

    // Request and payload held until granted
    assert property (@(posedge clk) disable iff (rst)
        bus_req && !bus_gnt |=> bus_req && $stable({bus_we, bus_addr, bus_be, bus_wdata}))
        else $error("bus request changed before grant");

    // Flagged requests are really unaligned and never issue
    assert property (@(posedge clk) disable iff (rst)
        misaligned |-> unaligned && !issue_request)
        else $error("misaligned request was issued");

    assert property (@(posedge clk) disable iff (rst) issue_request |-> !unaligned)
        else $error("unaligned request was issued");

endmodule

bind load_store_unit lsu_props i_lsu_props (
    .clk(clk),
    .rst(rst),
    .wb_valid(wb_valid),
    .wb_credit_return(wb_credit_return),
    .bus_req(bus_req),
    .bus_gnt(bus_gnt),
    .bus_we(bus_we),
    .bus_addr(bus_addr),
    .bus_be(bus_be),
    .bus_wdata(bus_wdata),
    .misaligned(misaligned),
    .issue_request(issue_request),
    .addr(addr),
    .width(rq_width)
);

`default_nettype wire

//--- verification/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    import lsu_pkg::*;

    localparam int NUM_REQUESTS = 138;
    localparam logic [31:0] BUS_BASE = 32'h8000_0100;

    logic clk = 1'b0;
    logic rst;
    logic req_valid;
    logic req_ready;
    logic req_load;
    logic req_store;
    ls_width_e req_width;
    logic [XLEN-1:0] req_base;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic [XLEN-1:0] req_store_data;
    logic wb_valid;
    logic [XLEN-1:0] wb_data;
    logic wb_credit_return;
    logic misaligned;
    logic bus_req;
    logic bus_we;
    logic [XLEN-1:0] bus_addr;
    logic [XLEN/8-1:0] bus_be;
    logic [XLEN-1:0] bus_wdata;
    logic bus_gnt;
    logic bus_rvalid;
    logic [XLEN-1:0] bus_rdata;

    logic [15:0] lfsr_state = 16'd33;
    logic [7:0] ref_mem [logic [31:0]];
    logic [7:0] bus_mem [logic [31:0]];
    logic [31:0] exp_q [$];
    logic [67:0] exp_bus_q [$];
    logic [31:0] resp_data_q [$];
    int resp_time_q [$];
    int cycle = 0;
    int error_count = 0;
    int delivered = 0;
    int returned = 0;
    int owed = 0;
    int misaligned_expected = 0;
    int misaligned_seen = 0;
    logic hold_credits = 1'b0;

    load_store_unit i_load_store_unit (.*);

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Unwritten bus bytes read back as a mix of all address bits
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    // Expected load result from the byte model
    function automatic logic [31:0] expected_load(input logic [31:0] a, input ls_width_e w);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_byte(a);
        b1 = ref_byte(a + 1);
        case (w)
            BYTE:    return {{24{b0[7]}}, b0};
            BYTE_U:  return {24'h0, b0};
            HALF:    return {{16{b1[7]}}, b1, b0};
            HALF_U:  return {16'h0, b1, b0};
            default: return {ref_byte(a + 3), ref_byte(a + 2), b1, b0};
        endcase
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    task automatic send_req(input logic is_load, input ls_width_e w,
                            input logic [31:0] a, input logic [31:0] data);
        logic [7:0] off;
        logic [3:0] be;
        logic [31:0] wd;
        logic bad;
        int nbytes;
        off = 8'(rand_bits(8));
        bad = ((w == HALF || w == HALF_U) && a[0]) || (w == WORD && a[1:0] != 2'b00);
        nbytes = (w == WORD) ? 4 : ((w == HALF || w == HALF_U) ? 2 : 1);
        if (bad) begin
            misaligned_expected++;
        end else if (is_load) begin
            exp_q.push_back(expected_load(a, w));
        end else begin
            be = (nbytes == 4) ? 4'b1111 : (nbytes == 2) ? (a[1] ? 4'b1100 : 4'b0011)
                                                         : (4'b0001 << a[1:0]);
            wd = (nbytes == 4) ? data : (nbytes == 2) ? {2{data[15:0]}} : {4{data[7:0]}};
            if (a[31:12] != 20'h0)
                exp_bus_q.push_back({a, be, wd});
            for (int i = 0; i < nbytes; i++)
                ref_mem[a + i] = data[i*8 +: 8];
        end
        @(posedge clk);
        req_valid <= 1'b1;
        req_load <= is_load;
        req_store <= !is_load;
        req_width <= w;
        req_offset <= {{4{off[7]}}, off};
        req_base <= a - {{24{off[7]}}, off};
        req_store_data <= data;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || exp_bus_q.size() != 0 || owed != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // Bus memory model with random grant and in-order read latency of 1 to 4
    always @(posedge clk) begin
        logic [31:0] word_addr;
        logic [31:0] rd;
        int t;
        cycle++;
        if (!rst && bus_req && bus_gnt) begin
            word_addr = {bus_addr[31:2], 2'b00};
            if (bus_we) begin
                assert (exp_bus_q.size() != 0) else report_error("unexpected bus write");
                if (exp_bus_q.size() != 0) begin
                    assert ({bus_addr, bus_be, bus_wdata} === exp_bus_q[0])
                        else report_error($sformatf("bus write %h/%b/%h, expected %h",
                                          bus_addr, bus_be, bus_wdata, exp_bus_q[0]));
                    void'(exp_bus_q.pop_front());
                end
                for (int i = 0; i < 4; i++)
                    if (bus_be[i])
                        bus_mem[word_addr + i] = bus_wdata[i*8 +: 8];
            end else begin
                for (int i = 0; i < 4; i++)
                    rd[i*8 +: 8] = bus_mem.exists(word_addr + i) ? bus_mem[word_addr + i]
                                                                 : fill_byte(word_addr + i);
                t = cycle + 1 + int'(rand_bits(2));
                if (resp_time_q.size() != 0 && t <= resp_time_q[$])
                    t = resp_time_q[$] + 1;
                resp_time_q.push_back(t);
                resp_data_q.push_back(rd);
            end
        end
        if (resp_time_q.size() != 0 && resp_time_q[0] <= cycle) begin
            bus_rvalid <= 1'b1;
            bus_rdata <= resp_data_q.pop_front();
            void'(resp_time_q.pop_front());
        end else begin
            bus_rvalid <= 1'b0;
            bus_rdata <= '0;
        end
        bus_gnt <= |rand_bits(2);
    end

    // Compare results and return credits
    always @(posedge clk) begin
        logic [31:0] expected;
        if (rst) begin
            wb_credit_return <= 1'b0;
        end else begin
            if (misaligned)
                misaligned_seen++;
            if (wb_valid) begin
                assert (delivered < WB_CREDITS + returned)
                    else report_error("result delivered without a credit");
                delivered++;
                owed++;
                assert (exp_q.size() != 0) else report_error("unexpected writeback result");
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    assert (wb_data === expected)
                        else report_error($sformatf("wb_data %h, expected %h", wb_data, expected));
                end
            end
            if (wb_credit_return) begin
                returned++;
                owed--;
            end
            wb_credit_return <= !hold_credits && owed > 0 && rand_bits(1);
        end
    end

    initial begin
        repeat (NUM_REQUESTS * 40) @(posedge clk);
        $display("Watchdog expired with %0d results still outstanding", exp_q.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst <= 1'b1;
        req_valid <= 1'b0;
        req_load <= 1'b0;
        req_store <= 1'b0;
        req_width <= WORD;
        req_base <= '0;
        req_offset <= '0;
        req_store_data <= '0;
        wb_credit_return <= 1'b0;
        bus_gnt <= 1'b0;
        bus_rvalid <= 1'b0;
        bus_rdata <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Word stores and loads in scratch
        for (int i = 0; i < 16; i++)
            send_req(1'b0, WORD, 32'h100 + 4 * i, rand_bits(32));
        for (int i = 0; i < 16; i++)
            send_req(1'b1, WORD, 32'h100 + 4 * i, 32'h0);
        wait_idle();

        // Mixed-width stores, then narrow loads at every offset
        for (int i = 0; i < 4; i++) begin
            send_req(1'b0, WORD, 32'h200 + 4 * i, rand_bits(32));
            send_req(1'b0, BYTE, 32'h200 + 4 * i + i, rand_bits(32));
            send_req(1'b0, HALF_U, 32'h200 + 4 * i + (i & 2), rand_bits(32));
            for (int b = 0; b < 4; b++) begin
                send_req(1'b1, BYTE, 32'h200 + 4 * i + b, 32'h0);
                send_req(1'b1, BYTE_U, 32'h200 + 4 * i + b, 32'h0);
            end
            for (int h = 0; h < 4; h += 2) begin
                send_req(1'b1, HALF, 32'h200 + 4 * i + h, 32'h0);
                send_req(1'b1, HALF_U, 32'h200 + 4 * i + h, 32'h0);
            end
        end
        wait_idle();

        // Bus stores of each width, then read back
        for (int i = 0; i < 8; i++)
            send_req(1'b0, (i % 3 == 0) ? BYTE : (i % 3 == 1) ? HALF : WORD,
                     BUS_BASE + 4 * i + ((i % 3 == 0) ? i % 4 : (i % 3 == 1) ? 2 : 0),
                     rand_bits(32));
        for (int i = 0; i < 8; i++)
            send_req(1'b1, WORD, BUS_BASE + 4 * i, 32'h0);
        wait_idle();

        // Misaligned requests are dropped
        send_req(1'b1, HALF, 32'h101, 32'h0);
        send_req(1'b0, WORD, 32'h106, 32'hdead_beef);
        send_req(1'b1, HALF_U, BUS_BASE + 3, 32'h0);
        send_req(1'b0, WORD, BUS_BASE + 5, 32'hcafe_f00d);
        send_req(1'b1, WORD, 32'h104, 32'h0);
        send_req(1'b1, WORD, 32'h100, 32'h0);
        send_req(1'b1, WORD, BUS_BASE, 32'h0);
        send_req(1'b1, WORD, BUS_BASE + 4, 32'h0);
        wait_idle();

        // Alternate units to exercise ordering
        for (int i = 0; i < 16; i++)
            send_req(1'b1, WORD, (i % 2 == 0) ? 32'h100 + 2 * i : BUS_BASE + 2 * (i - 1),
                     32'h0);
        wait_idle();

        // Withhold credits, then release them
        hold_credits <= 1'b1;
        for (int i = 0; i < 6; i++)
            send_req(1'b1, WORD, 32'h13c - 4 * i, 32'h0);
        repeat (40) @(posedge clk);
        assert (exp_q.size() == 6 - WB_CREDITS)
            else report_error($sformatf("%0d results pending while credits held, expected %0d",
                              exp_q.size(), 6 - WB_CREDITS));
        hold_credits <= 1'b0;
        wait_idle();

        assert (misaligned_seen == misaligned_expected)
            else report_error($sformatf("%0d misaligned pulses, expected %0d",
                              misaligned_seen, misaligned_expected));
        $display("Results %0d, credits returned %0d, misaligned %0d, errors %0d",
                 delivered, returned, misaligned_seen, error_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/lsu_pkg.sv
src/lsu_fifo.sv
src/ls_request_decode.sv
src/scratch_ram.sv
src/mem_bus_port.sv
src/load_align.sv
src/load_store_unit.sv
verification/lsu_props.sv
verification/lsu_tb.sv

//--- Bender.yml
package:
  name: load_store_unit

sources:
  - src/lsu_pkg.sv
  - src/lsu_fifo.sv
  - src/ls_request_decode.sv
  - src/scratch_ram.sv
  - src/mem_bus_port.sv
  - src/load_align.sv
  - src/load_store_unit.sv
  - target: test
    files:
      - verification/lsu_props.sv
      - verification/lsu_tb.sv
